// ==== design/cbm2_loader_pkg.sv ====
package cbm2_loader_pkg;

	// Address space of the shared RAM with the 64K bank in bits 24..16
	typedef logic [24:0] ram_addr_t;
	typedef logic [7:0]  byte_t;

	// Download index as sent by the host
	// Whole byte for slots 1..9 or sub-select plus file slot for system images
	typedef union packed {
		byte_t raw;
		struct packed {
			logic [1:0] sub;
			logic [5:0] slot;
		} f;
	} dl_index_u;

	// ==========================================================
	// Download slots
	// ==========================================================
	localparam byte_t SLOT_P500    = 8'd1;
	localparam byte_t SLOT_B6X0    = 8'd2;
	localparam byte_t SLOT_B7X0    = 8'd3;
	localparam byte_t SLOT_EXT2000 = 8'd4;
	localparam byte_t SLOT_EXT4000 = 8'd5;
	localparam byte_t SLOT_EXT6000 = 8'd6;
	localparam byte_t SLOT_DRV4040 = 8'd7;
	localparam byte_t SLOT_DRV8250 = 8'd8;
	localparam byte_t SLOT_PRG     = 8'd9;

	// ==========================================================
	// ROM load windows
	// ==========================================================
	localparam ram_addr_t BASE_P500    = 25'h102_0000;
	localparam ram_addr_t BASE_B6X0    = 25'h100_0000;
	localparam ram_addr_t BASE_B7X0    = 25'h101_0000;
	localparam ram_addr_t BASE_EXT2000 = 25'h103_2000;
	localparam ram_addr_t BASE_EXT4000 = 25'h103_4000;
	localparam ram_addr_t BASE_EXT6000 = 25'h103_6000;

	// Bytes past these counts are dropped
	localparam logic [15:0] LIMIT_SYS_ROM = 16'hB000;
	localparam logic [15:0] LIMIT_EXT_ROM = 16'h2000;

	// Character generator lives at $A000-$AFFF of the system image
	localparam logic [3:0] CHRGEN_NIBBLE = 4'hA;

	localparam int DRV_ROM_LIMIT_BITS = 15;

	// ==========================================================
	// Bank 15 zero page and BASIC pointers
	// ==========================================================
	localparam ram_addr_t ZP_BANK15      = 25'h00F_0000;
	localparam byte_t     PTR_TXTTAB_LO  = 8'h2D;
	localparam byte_t     PTR_TXTTAB_HI  = 8'h2E;
	localparam byte_t     PTR_TXTEND_LO  = 8'h2F;
	localparam byte_t     PTR_TXTEND_HI  = 8'h30;

	// ==========================================================
	// Erase ranges
	// ==========================================================
	localparam ram_addr_t ERASE_END_ZP    = 25'h00F_0FFF;
	localparam ram_addr_t ERASE_VID_START = 25'h00F_D000;
	localparam ram_addr_t ERASE_END_ALL   = 25'h00F_D7FF;

	// Last main RAM byte per size and model
	localparam ram_addr_t RAM_TOP_128P = 25'h001_FFFF;
	localparam ram_addr_t RAM_TOP_128B = 25'h002_FFFF;
	localparam ram_addr_t RAM_TOP_256P = 25'h003_FFFF;
	localparam ram_addr_t RAM_TOP_256B = 25'h004_FFFF;

	typedef enum logic [1:0] {
		NONE  = 2'd0,
		SHORT = 2'd1,
		FULL  = 2'd2
	} erase_mode_e;

endpackage

// ==== design/rom_loader.sv ====
`timescale 1ns/1ps

module rom_loader (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      ioctl_wr_i,
	input  cbm2_loader_pkg::ram_addr_t ioctl_addr_i,
	input  cbm2_loader_pkg::byte_t    ioctl_data_i,
	input  cbm2_loader_pkg::byte_t    ioctl_index_i,
	input  logic                      ioctl_download_i,
	input  logic                      model_i,
	input  logic                      grant_i,
	output logic                      req_o,
	output cbm2_loader_pkg::ram_addr_t addr_o,
	output cbm2_loader_pkg::byte_t    data_o,
	output logic                      chrgen_wr_o,
	output logic                      drv_rom_wr_o,
	output logic                      drv_rom_sel_o,
	output logic [2:0]                extbankrom_o,
	output logic                      prg_done_o,
	output logic [15:0]               prg_start_o,
	output logic [15:0]               prg_end_o
);
	import cbm2_loader_pkg::*;

	dl_index_u idx;
	logic      is_rom;
	logic      rom_slot0;
	logic      ld_p500, ld_b6x0, ld_b7x0;
	logic      ld_ext2000, ld_ext4000, ld_ext6000;
	logic      ld_4040, ld_8250, ld_prg;
	logic      ext_sel, sys_sel;
	logic      in_ext_limit, in_sys_limit;
	logic      win_start, load_byte;
	logic      dl_q;
	ram_addr_t base_addr;

	// ==========================================================
	// Index decode
	// ==========================================================
	assign idx       = dl_index_u'(ioctl_index_i);
	assign is_rom    = idx.f.slot < 6'd7;
	assign rom_slot0 = is_rom && idx.f.slot == 6'd0;

	// Slot 0 with a sub-select comes from the system ROM menu entries
	assign ld_p500    = idx.raw == SLOT_P500 || (rom_slot0 && idx.f.sub == 2'd0);
	assign ld_b6x0    = idx.raw == SLOT_B6X0 || (rom_slot0 && idx.f.sub == 2'd1);
	assign ld_b7x0    = idx.raw == SLOT_B7X0 || (rom_slot0 && idx.f.sub == 2'd2);
	assign ld_ext2000 = idx.raw == SLOT_EXT2000;
	assign ld_ext4000 = idx.raw == SLOT_EXT4000;
	assign ld_ext6000 = idx.raw == SLOT_EXT6000;
	assign ld_4040    = idx.raw == SLOT_DRV4040;
	assign ld_8250    = idx.raw == SLOT_DRV8250;
	assign ld_prg     = idx.raw == SLOT_PRG;

	assign ext_sel      = ld_ext2000 || ld_ext4000 || ld_ext6000;
	assign sys_sel      = ld_p500 || ld_b6x0 || ld_b7x0;
	assign in_ext_limit = ioctl_addr_i < ram_addr_t'(LIMIT_EXT_ROM);
	assign in_sys_limit = ioctl_addr_i < ram_addr_t'(LIMIT_SYS_ROM);

	assign win_start = ioctl_wr_i && (ext_sel || sys_sel) && ioctl_addr_i == '0;

	// PRG payload starts after the two header bytes
	assign load_byte = ioctl_wr_i && ((ext_sel && in_ext_limit) || (sys_sel && in_sys_limit)
		|| (ld_prg && ioctl_addr_i[24:1] != '0));

	always_comb begin
		base_addr = BASE_P500;
		if (ld_b6x0)
			base_addr = BASE_B6X0;
		else if (ld_b7x0)
			base_addr = BASE_B7X0;
		else if (ld_ext2000)
			base_addr = BASE_EXT2000;
		else if (ld_ext4000)
			base_addr = BASE_EXT4000;
		else if (ld_ext6000)
			base_addr = BASE_EXT6000;
	end

	// ==========================================================
	// Request and strobes
	// ==========================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			req_o         <= 1'b0;
			chrgen_wr_o   <= 1'b0;
			drv_rom_wr_o  <= 1'b0;
			drv_rom_sel_o <= 1'b0;
			extbankrom_o  <= 3'b000;
			prg_done_o    <= 1'b0;
			dl_q          <= 1'b0;
		end else begin
			dl_q       <= ioctl_download_i;
			prg_done_o <= dl_q && !ioctl_download_i && ld_prg;

			if (grant_i)
				req_o <= 1'b0;
			if (load_byte)
				req_o <= 1'b1;

			chrgen_wr_o <= ioctl_wr_i && (ld_b6x0 || ld_b7x0) && in_sys_limit
				&& ioctl_addr_i[15:12] == CHRGEN_NIBBLE;

			// Drive images only fill the lower 32K
			drv_rom_wr_o  <= (ld_4040 || ld_8250) && ioctl_download_i && ioctl_wr_i
				&& ioctl_addr_i[24:DRV_ROM_LIMIT_BITS] == '0;
			drv_rom_sel_o <= ld_4040;

			extbankrom_o <= extbankrom_o | {ioctl_wr_i && ld_ext6000,
				ioctl_wr_i && ld_ext4000, ioctl_wr_i && ld_ext2000};
		end
	end

	// Load address, byte and BASIC pointers
	always_ff @(posedge clk_sys) begin
		if (grant_i)
			addr_o <= addr_o + 1'b1;
		if (win_start)
			addr_o <= base_addr;
		if (ioctl_wr_i && ld_prg) begin
			if (ioctl_addr_i == '0) begin
				addr_o[24:16]    <= {8'd0, model_i};
				addr_o[7:0]      <= ioctl_data_i;
				prg_start_o[7:0] <= ioctl_data_i;
				prg_end_o[7:0]   <= ioctl_data_i;
			end else if (ioctl_addr_i == ram_addr_t'(1)) begin
				addr_o[15:8]      <= ioctl_data_i;
				prg_start_o[15:8] <= ioctl_data_i;
				prg_end_o[15:8]   <= ioctl_data_i;
			end else begin
				prg_end_o <= prg_end_o + 1'b1;
			end
		end
		if (load_byte)
			data_o <= ioctl_data_i;
	end

endmodule

// ==== design/prg_injector.sv ====
`timescale 1ns/1ps

module prg_injector (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      prg_done_i,
	input  logic [15:0]               prg_start_i,
	input  logic [15:0]               prg_end_i,
	input  logic                      grant_i,
	output logic                      req_o,
	output cbm2_loader_pkg::ram_addr_t addr_o,
	output cbm2_loader_pkg::byte_t    data_o
);
	import cbm2_loader_pkg::*;

	logic busy_q;

	// Walks zero page of bank 15, stopping only at the four BASIC pointers
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			busy_q <= 1'b0;
			req_o  <= 1'b0;
		end else begin
			if (prg_done_i && !busy_q)
				busy_q <= 1'b1;
			if (grant_i)
				req_o <= 1'b0;
			else if (busy_q && !req_o) begin
				if (addr_o[8])
					busy_q <= 1'b0;
				else if (addr_o[7:0] inside {PTR_TXTTAB_LO, PTR_TXTTAB_HI,
						PTR_TXTEND_LO, PTR_TXTEND_HI})
					req_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (prg_done_i && !busy_q)
			addr_o <= ZP_BANK15;
		else if (grant_i)
			addr_o <= addr_o + 1'b1;
		else if (busy_q && !req_o && !addr_o[8]) begin
			case (addr_o[7:0])
				PTR_TXTTAB_LO: data_o <= prg_start_i[7:0];
				PTR_TXTTAB_HI: data_o <= prg_start_i[15:8];
				PTR_TXTEND_LO: data_o <= prg_end_i[7:0];
				PTR_TXTEND_HI: data_o <= prg_end_i[15:8];
				// Skip the rest of zero page
				default:       addr_o <= addr_o + 1'b1;
			endcase
		end
	end

endmodule

// ==== design/ram_eraser.sv ====
`timescale 1ns/1ps

module ram_eraser #(
	parameter int ERASE_PACE_BITS = 5
) (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  cbm2_loader_pkg::erase_mode_e erase_mode_i,
	input  logic                        model_i,
	input  logic [1:0]                  ramsize_i,
	input  logic                        grant_i,
	output logic                        req_o,
	output cbm2_loader_pkg::ram_addr_t  addr_o,
	output cbm2_loader_pkg::byte_t      data_o,
	output logic                        erasing_o
);
	import cbm2_loader_pkg::*;

	erase_mode_e                mode_q;
	erase_mode_e                mode_in_q;
	logic [ERASE_PACE_BITS-1:0] pace_q;
	logic                       start;
	logic                       at_top;
	logic                       done;
	ram_addr_t                  ram_top;
	ram_addr_t                  next_addr;

	// New request only on a change away from NONE
	assign start     = mode_q == NONE && mode_in_q == NONE && erase_mode_i != NONE;
	assign erasing_o = mode_q != NONE;
	assign data_o    = {8{addr_o[14] ^ addr_o[3] ^ addr_o[2]}};

	always_comb begin
		case (ramsize_i[0])
			1'b0:    ram_top = model_i ? RAM_TOP_128B : RAM_TOP_128P;
			default: ram_top = model_i ? RAM_TOP_256B : RAM_TOP_256P;
		endcase
	end

	// 896K has no gap up to bank 15
	assign at_top = !ramsize_i[1] && addr_o == ram_top;

	always_comb begin
		done      = 1'b0;
		next_addr = addr_o + 1'b1;
		if (at_top)
			next_addr = ZP_BANK15;
		else if (mode_q == SHORT && addr_o == ERASE_END_ZP)
			next_addr = ERASE_VID_START;
		else if (addr_o == ERASE_END_ALL)
			done = 1'b1;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			mode_q    <= NONE;
			mode_in_q <= NONE;
			req_o     <= 1'b0;
			pace_q    <= '0;
		end else begin
			mode_in_q <= erase_mode_i;
			if (start)
				mode_q <= erase_mode_i;
			// Pace writes so CPU slots are not starved
			if (mode_q != NONE && !req_o) begin
				pace_q <= pace_q + 1'b1;
				if (&pace_q)
					req_o <= 1'b1;
			end
			if (grant_i) begin
				req_o <= 1'b0;
				if (done)
					mode_q <= NONE;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start)
			addr_o <= (erase_mode_i == FULL) ? {8'd0, model_i, 16'd0} : ZP_BANK15;
		else if (grant_i)
			addr_o <= next_addr;
	end

endmodule

// ==== design/io_cycle_port.sv ====
`timescale 1ns/1ps

module io_cycle_port (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      io_cycle_i,
	input  logic                      erase_req_i,
	input  cbm2_loader_pkg::ram_addr_t erase_addr_i,
	input  cbm2_loader_pkg::byte_t    erase_data_i,
	input  logic                      inj_req_i,
	input  cbm2_loader_pkg::ram_addr_t inj_addr_i,
	input  cbm2_loader_pkg::byte_t    inj_data_i,
	input  logic                      load_req_i,
	input  cbm2_loader_pkg::ram_addr_t load_addr_i,
	input  cbm2_loader_pkg::byte_t    load_data_i,
	output logic                      erase_grant_o,
	output logic                      inj_grant_o,
	output logic                      load_grant_o,
	input  cbm2_loader_pkg::ram_addr_t cpu_addr_i,
	input  logic                      cpu_ce_i,
	input  logic                      cpu_we_i,
	input  cbm2_loader_pkg::byte_t    cpu_data_i,
	output cbm2_loader_pkg::ram_addr_t ram_addr_o,
	output logic                      ram_ce_o,
	output logic                      ram_we_o,
	output cbm2_loader_pkg::byte_t    ram_data_o
);
	import cbm2_loader_pkg::*;

	logic      io_q;
	logic      io_fall;
	logic      io_rise;
	logic      ce_q;
	logic      we_q;
	ram_addr_t addr_q;
	byte_t     data_q;

	assign io_fall = io_q && !io_cycle_i;
	assign io_rise = !io_q && io_cycle_i;

	// Eraser wins over injector, injector over loader
	assign erase_grant_o = io_fall && erase_req_i;
	assign inj_grant_o   = io_fall && inj_req_i && !erase_req_i;
	assign load_grant_o  = io_fall && load_req_i && !erase_req_i && !inj_req_i;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			io_q <= 1'b0;
			ce_q <= 1'b0;
			we_q <= 1'b0;
		end else begin
			io_q <= io_cycle_i;
			if (io_fall) begin
				ce_q <= 1'b1;
				// Empty slot becomes a plain read
				we_q <= erase_req_i || inj_req_i || load_req_i;
			end else if (io_rise) begin
				ce_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (erase_grant_o) begin
			addr_q <= erase_addr_i;
			data_q <= erase_data_i;
		end else if (inj_grant_o) begin
			addr_q <= inj_addr_i;
			data_q <= inj_data_i;
		end else if (load_grant_o) begin
			addr_q <= load_addr_i;
			data_q <= load_data_i;
		end
	end

	// I/O slot owns the bus while io_cycle_i is high
	assign ram_addr_o = io_cycle_i ? addr_q : cpu_addr_i;
	assign ram_ce_o   = io_cycle_i ? ce_q   : cpu_ce_i;
	assign ram_we_o   = io_cycle_i ? we_q   : cpu_we_i;
	assign ram_data_o = io_cycle_i ? data_q : cpu_data_i;

endmodule

// ==== design/cbm2_loader.sv ====
`timescale 1ns/1ps

module cbm2_loader #(
	parameter int ERASE_PACE_BITS = 5
) (
	input  logic                        clk_sys,
	input  logic                        RESET,
	input  logic                        ioctl_wr_i,
	input  cbm2_loader_pkg::ram_addr_t  ioctl_addr_i,
	input  cbm2_loader_pkg::byte_t      ioctl_data_i,
	input  cbm2_loader_pkg::byte_t      ioctl_index_i,
	input  logic                        ioctl_download_i,
	output logic                        ioctl_wait_o,
	input  logic                        model_i,
	input  logic [1:0]                  ramsize_i,
	input  cbm2_loader_pkg::erase_mode_e erase_mode_i,
	input  logic                        io_cycle_i,
	input  cbm2_loader_pkg::ram_addr_t  cpu_addr_i,
	input  logic                        cpu_ce_i,
	input  logic                        cpu_we_i,
	input  cbm2_loader_pkg::byte_t      cpu_data_i,
	output cbm2_loader_pkg::ram_addr_t  ram_addr_o,
	output logic                        ram_ce_o,
	output logic                        ram_we_o,
	output cbm2_loader_pkg::byte_t      ram_data_o,
	output logic                        chrgen_wr_o,
	output logic                        drv_rom_wr_o,
	output logic                        drv_rom_sel_o,
	output logic [2:0]                  extbankrom_o,
	output logic                        erasing_o
);
	import cbm2_loader_pkg::*;

	logic        load_req, load_grant;
	ram_addr_t   load_addr;
	byte_t       load_data;
	logic        inj_req, inj_grant;
	ram_addr_t   inj_addr;
	byte_t       inj_data;
	logic        erase_req, erase_grant;
	ram_addr_t   erase_addr;
	byte_t       erase_data;
	logic        prg_done;
	logic [15:0] prg_start, prg_end;

	// Host holds off while a loader byte waits for its slot
	assign ioctl_wait_o = load_req;

	// ==========================================================
	// Write sources
	// ==========================================================
	rom_loader i_rom_loader (
		.clk_sys, .RESET, .ioctl_wr_i, .ioctl_addr_i, .ioctl_data_i, .ioctl_index_i,
		.ioctl_download_i, .model_i, .grant_i(load_grant), .req_o(load_req),
		.addr_o(load_addr), .data_o(load_data), .chrgen_wr_o, .drv_rom_wr_o, .drv_rom_sel_o,
		.extbankrom_o, .prg_done_o(prg_done), .prg_start_o(prg_start), .prg_end_o(prg_end)
	);

	prg_injector i_prg_injector (
		.clk_sys, .RESET, .prg_done_i(prg_done), .prg_start_i(prg_start),
		.prg_end_i(prg_end), .grant_i(inj_grant), .req_o(inj_req),
		.addr_o(inj_addr), .data_o(inj_data)
	);

	ram_eraser #(.ERASE_PACE_BITS(ERASE_PACE_BITS)) i_ram_eraser (
		.clk_sys, .RESET, .erase_mode_i, .model_i, .ramsize_i, .grant_i(erase_grant),
		.req_o(erase_req), .addr_o(erase_addr), .data_o(erase_data), .erasing_o
	);

	// ==========================================================
	// RAM bus
	// ==========================================================
	io_cycle_port i_io_cycle_port (
		.clk_sys, .RESET, .io_cycle_i,
		.erase_req_i(erase_req), .erase_addr_i(erase_addr), .erase_data_i(erase_data),
		.inj_req_i(inj_req), .inj_addr_i(inj_addr), .inj_data_i(inj_data),
		.load_req_i(load_req), .load_addr_i(load_addr), .load_data_i(load_data),
		.erase_grant_o(erase_grant), .inj_grant_o(inj_grant), .load_grant_o(load_grant),
		.cpu_addr_i, .cpu_ce_i, .cpu_we_i, .cpu_data_i,
		.ram_addr_o, .ram_ce_o, .ram_we_o, .ram_data_o
	);

endmodule

// ==== sim/tb_cbm2_loader.sv ====
`timescale 1ns/1ps

module tb_cbm2_loader;
	import cbm2_loader_pkg::*;

	localparam int SC_EXT         = 0;
	localparam int SC_SYS         = 1;
	localparam int SC_PRG         = 2;
	localparam int SC_DRV         = 3;
	localparam int SC_ERASE_FULL  = 4;
	localparam int SC_ERASE_SHORT = 5;

	logic        clk_sys = 1'b0;
	logic        RESET;
	logic        ioctl_wr_i;
	ram_addr_t   ioctl_addr_i;
	byte_t       ioctl_data_i;
	byte_t       ioctl_index_i;
	logic        ioctl_download_i;
	logic        ioctl_wait_o;
	logic        model_i;
	logic [1:0]  ramsize_i;
	erase_mode_e erase_mode_i;
	logic        io_cycle_i;
	ram_addr_t   cpu_addr_i;
	logic        cpu_ce_i;
	logic        cpu_we_i;
	byte_t       cpu_data_i;
	ram_addr_t   ram_addr_o;
	logic        ram_ce_o;
	logic        ram_we_o;
	byte_t       ram_data_o;
	logic        chrgen_wr_o;
	logic        drv_rom_wr_o;
	logic        drv_rom_sel_o;
	logic [2:0]  extbankrom_o;
	logic        erasing_o;

	// RAM model and per-phase bookkeeping
	byte_t       ram_model [ram_addr_t];
	byte_t       rom_data [0:65535];
	byte_t       prg_data [0:255];
	logic [15:0] prg_start;
	int          prg_len;
	int          scenario;
	int          errors = 0;
	int          checks = 0;
	int          chrgen_pulses = 0;
	int          drv_pulses = 0;
	int          io_left = 2;
	logic        ce_seen = 1'b0;

	cbm2_loader #(.ERASE_PACE_BITS(2)) i_dut (
		.clk_sys, .RESET, .ioctl_wr_i, .ioctl_addr_i, .ioctl_data_i, .ioctl_index_i,
		.ioctl_download_i, .ioctl_wait_o, .model_i, .ramsize_i, .erase_mode_i, .io_cycle_i,
		.cpu_addr_i, .cpu_ce_i, .cpu_we_i, .cpu_data_i,
		.ram_addr_o, .ram_ce_o, .ram_we_o, .ram_data_o,
		.chrgen_wr_o, .drv_rom_wr_o, .drv_rom_sel_o, .extbankrom_o, .erasing_o
	);

	always #5 clk_sys = ~clk_sys;

	// Expected byte at a RAM address for a scenario or -1 when no write is expected
	function automatic int expected_byte(input ram_addr_t addr, input int sc);
		ram_addr_t   off;
		ram_addr_t   prg_base;
		logic [15:0] prg_end;
		logic        pat;
		int          result;
		result   = -1;
		prg_base = {8'd0, 1'b1, prg_start};
		prg_end  = prg_start + 16'(prg_len);
		pat      = addr[14] ^ addr[3] ^ addr[2];
		case (sc)
			SC_EXT: begin
				off = addr - BASE_EXT2000;
				if (addr >= BASE_EXT2000 && off < LIMIT_EXT_ROM)
					result = rom_data[off[15:0]];
			end
			SC_SYS: begin
				off = addr - BASE_B6X0;
				if (addr >= BASE_B6X0 && off < LIMIT_SYS_ROM)
					result = rom_data[off[15:0]];
			end
			SC_PRG: begin
				off = addr - prg_base;
				if (addr >= prg_base && off < prg_len)
					result = prg_data[off[7:0]];
				else if (addr == ZP_BANK15 + PTR_TXTTAB_LO)
					result = prg_start[7:0];
				else if (addr == ZP_BANK15 + PTR_TXTTAB_HI)
					result = prg_start[15:8];
				else if (addr == ZP_BANK15 + PTR_TXTEND_LO)
					result = prg_end[7:0];
				else if (addr == ZP_BANK15 + PTR_TXTEND_HI)
					result = prg_end[15:8];
			end
			SC_ERASE_FULL: begin
				if (addr <= RAM_TOP_128P || (addr >= ZP_BANK15 && addr <= ERASE_END_ALL))
					result = pat ? 255 : 0;
			end
			SC_ERASE_SHORT: begin
				if ((addr >= ZP_BANK15 && addr <= ERASE_END_ZP)
					|| (addr >= ERASE_VID_START && addr <= ERASE_END_ALL))
					result = pat ? 255 : 0;
			end
			default: ;
		endcase
		return result;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// ==========================================================
	// I/O slots and random CPU traffic
	// ==========================================================
	always @(negedge clk_sys) begin : bus_drive
		logic [31:0] rnd;
		rnd        = $urandom;
		cpu_addr_i = rnd[24:0];
		cpu_ce_i   = rnd[25];
		cpu_we_i   = rnd[26];
		rnd        = $urandom;
		cpu_data_i = rnd[7:0];
		if (io_left == 0) begin
			io_cycle_i = !io_cycle_i;
			io_left    = io_cycle_i ? $urandom_range(4, 1) - 1 : $urandom_range(6, 2) - 1;
		end else begin
			io_left--;
		end
	end

	// RAM model with one write per ce pulse checked against the reference
	always @(posedge clk_sys) begin : ram_write_check
		int exp_val;
		if (!RESET && io_cycle_i && ram_ce_o && ram_we_o && !ce_seen) begin
			exp_val = expected_byte(ram_addr_o, scenario);
			ram_model[ram_addr_o] = ram_data_o;
			checks++;
			assert (exp_val >= 0) else begin
				errors++;
				$display("Unexpected RAM write of %h at address %h", ram_data_o, ram_addr_o);
			end
			if (exp_val >= 0) begin
				assert (int'(ram_data_o) == exp_val) else begin
					errors++;
					$display("Fail ram_data_o at %h: got %h expected %h",
						ram_addr_o, ram_data_o, exp_val[7:0]);
				end
			end
		end
		ce_seen = io_cycle_i && ram_ce_o;
		if (chrgen_wr_o)
			chrgen_pulses++;
		if (drv_rom_wr_o)
			drv_pulses++;
	end

	// CPU owns the bus outside I/O slots
	always @(posedge clk_sys) begin
		if (!RESET && !io_cycle_i) begin
			check_value("ram_addr_o", ram_addr_o, cpu_addr_i);
			check_value("ram_ce_o", ram_ce_o, cpu_ce_i);
			check_value("ram_we_o", ram_we_o, cpu_we_i);
			check_value("ram_data_o", ram_data_o, cpu_data_i);
		end
	end

	// ==========================================================
	// Host side tasks
	// ==========================================================
	task automatic upload_byte(input ram_addr_t addr, input byte_t data);
		logic exp_chr;
		logic exp_drv;
		int   n;
		exp_chr = (ioctl_index_i == SLOT_B6X0 || ioctl_index_i == SLOT_B7X0)
			&& addr < LIMIT_SYS_ROM && addr[15:12] == CHRGEN_NIBBLE;
		exp_drv = (ioctl_index_i == SLOT_DRV4040 || ioctl_index_i == SLOT_DRV8250)
			&& addr < (25'd1 << DRV_ROM_LIMIT_BITS);
		@(negedge clk_sys);
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		ioctl_wr_i   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
		check_value("chrgen_wr_o", chrgen_wr_o, exp_chr);
		check_value("drv_rom_wr_o", drv_rom_wr_o, exp_drv);
		if (exp_drv)
			check_value("drv_rom_sel_o", drv_rom_sel_o, ioctl_index_i == SLOT_DRV4040);
		n = 0;
		while (ioctl_wait_o && n < 100) begin
			@(negedge clk_sys);
			n++;
		end
		assert (!ioctl_wait_o) else begin
			errors++;
			$display("Timeout waiting for ioctl_wait_o to fall after file address %h", addr);
		end
	endtask

	task automatic upload_range(input byte_t index, input int first, input int last);
		logic [31:0] rnd;
		@(negedge clk_sys);
		ioctl_index_i    = index;
		ioctl_download_i = 1'b1;
		for (int i = first; i <= last; i++) begin
			rnd = $urandom;
			rom_data[i] = rnd[7:0];
			upload_byte(ram_addr_t'(i), rom_data[i]);
		end
		@(negedge clk_sys);
		ioctl_download_i = 1'b0;
	endtask

	task automatic start_phase(input int sc);
		@(negedge clk_sys);
		scenario      = sc;
		chrgen_pulses = 0;
		drv_pulses    = 0;
		ram_model.delete();
	endtask

	// Last write reaches the bus some slots after its grant
	task automatic wait_ram_count(input int count, input int limit);
		int n;
		n = 0;
		while (ram_model.num() < count && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		assert (ram_model.num() >= count) else begin
			errors++;
			$display("Timeout waiting for %0d RAM writes", count);
		end
		check_value("ram write count", ram_model.num(), count);
	endtask

	task automatic run_erase(input erase_mode_e mode, input int count);
		int n;
		@(negedge clk_sys);
		erase_mode_i = mode;
		@(negedge clk_sys);
		check_value("erasing_o", erasing_o, 1'b1);
		n = 0;
		while (erasing_o && n < 5000000) begin
			@(negedge clk_sys);
			n++;
		end
		assert (!erasing_o) else begin
			errors++;
			$display("Timeout waiting for erasing_o to fall");
		end
		erase_mode_i = NONE;
		wait_ram_count(count, 100);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial begin : main
		logic [31:0] rnd;
		void'($urandom(32'h826e633b));
		RESET            = 1'b1;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		ioctl_index_i    = '0;
		ioctl_download_i = 1'b0;
		model_i          = 1'b0;
		ramsize_i        = 2'd0;
		erase_mode_i     = NONE;
		io_cycle_i       = 1'b0;
		cpu_addr_i       = '0;
		cpu_ce_i         = 1'b0;
		cpu_we_i         = 1'b0;
		cpu_data_i       = '0;
		scenario         = SC_EXT;
		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		check_value("ioctl_wait_o", ioctl_wait_o, 1'b0);
		check_value("erasing_o", erasing_o, 1'b0);
		check_value("chrgen_wr_o", chrgen_wr_o, 1'b0);
		check_value("drv_rom_wr_o", drv_rom_wr_o, 1'b0);
		check_value("extbankrom_o", extbankrom_o, 3'b000);

		// Extension ROM past its window size
		start_phase(SC_EXT);
		upload_range(SLOT_EXT2000, 0, 32'h201F);
		wait_ram_count(32'h2000, 100);
		check_value("extbankrom_o", extbankrom_o, 3'b001);
		check_value("chrgen_wr_o pulse count", chrgen_pulses, 0);

		// B6x0 system image with the character generator
		start_phase(SC_SYS);
		upload_range(SLOT_B6X0, 0, 32'hB01F);
		wait_ram_count(32'hB000, 100);
		check_value("chrgen_wr_o pulse count", chrgen_pulses, 32'h1000);

		// PRG for model B and then the BASIC pointers
		start_phase(SC_PRG);
		rnd       = $urandom_range(32'h7000, 32'h0400);
		prg_start = rnd[15:0];
		prg_len   = 48;
		for (int i = 0; i < prg_len; i++) begin
			rnd = $urandom;
			prg_data[i] = rnd[7:0];
		end
		@(negedge clk_sys);
		model_i          = 1'b1;
		ioctl_index_i    = SLOT_PRG;
		ioctl_download_i = 1'b1;
		upload_byte(ram_addr_t'(0), prg_start[7:0]);
		upload_byte(ram_addr_t'(1), prg_start[15:8]);
		for (int i = 0; i < prg_len; i++)
			upload_byte(ram_addr_t'(i + 2), prg_data[i]);
		@(negedge clk_sys);
		ioctl_download_i = 1'b0;
		wait_ram_count(prg_len + 4, 2000);

		// 4040 drive image around the 32K boundary
		start_phase(SC_DRV);
		upload_range(SLOT_DRV4040, 32'h7F00, 32'h80FF);
		wait_ram_count(0, 10);
		check_value("drv_rom_wr_o pulse count", drv_pulses, 256);

		// Erase for model P with 128K
		start_phase(SC_ERASE_FULL);
		model_i   = 1'b0;
		ramsize_i = 2'd0;
		run_erase(FULL, 32'h20000 + 32'hD800);
		start_phase(SC_ERASE_SHORT);
		run_erase(SHORT, 32'h1000 + 32'h800);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== cbm2_loader.f ====
design/cbm2_loader_pkg.sv
design/rom_loader.sv
design/prg_injector.sv
design/ram_eraser.sv
design/io_cycle_port.sv
design/cbm2_loader.sv
sim/tb_cbm2_loader.sv

// ==== Bender.yml ====
package:
  name: cbm2_loader

sources:
  - files:
      - design/cbm2_loader_pkg.sv
      - design/rom_loader.sv
      - design/prg_injector.sv
      - design/ram_eraser.sv
      - design/io_cycle_port.sv
      - design/cbm2_loader.sv
  - target: simulation
    files:
      - sim/tb_cbm2_loader.sv
